// File: rtl/cam_lookup_params.svh
/* CAM lookup sizes and register map */
`ifndef CAM_LOOKUP_PARAMS_SVH
`define CAM_LOOKUP_PARAMS_SVH

`define CAM_ELS         8
`define CAM_TAG_W       8
`define CAM_VAL_W       16
`define CAM_IDX_W       3

`define APB_ADDR_W      8
`define APB_DATA_W      32

// Register offsets
`define CAM_REG_INSERT  8'h00
`define CAM_REG_DELETE  8'h04
`define CAM_REG_LOOKUP  8'h08
`define CAM_REG_RESULT  8'h0C
`define CAM_REG_STATUS  8'h10

`endif

// File: rtl/cam_lookup_pkg.sv
/* CAM lookup types */
`include "cam_lookup_params.svh"

package cam_lookup_pkg;

  typedef enum logic [1:0] {
    OP_INSERT,
    OP_DELETE,
    OP_LOOKUP
  } cam_op_e;

  typedef enum logic [1:0] {
    RD_RESULT,
    RD_STATUS,
    RD_NONE
  } cam_rd_sel_e;

  // INSERT word: tag and value side by side
  typedef struct packed {
    logic [`APB_DATA_W-`CAM_TAG_W-`CAM_VAL_W-1:0] rsvd;
    logic [`CAM_TAG_W-1:0]                        tag;
    logic [`CAM_VAL_W-1:0]                        value;
  } cam_ins_t;

  // DELETE and LOOKUP word: tag in the low byte
  typedef struct packed {
    logic [`APB_DATA_W-`CAM_TAG_W-1:0] rsvd;
    logic [`CAM_TAG_W-1:0]             tag;
  } cam_key_t;

  typedef union packed {
    cam_ins_t ins;
    cam_key_t key;
  } cam_wdata_u;

endpackage

// File: rtl/cam_lookup_if.sv
/* CAM command and result interfaces */
`include "cam_lookup_params.svh"

interface cam_cmd_if;
  import cam_lookup_pkg::*;

  logic                  cmd_v;
  cam_op_e               op;
  logic [`CAM_TAG_W-1:0] tag;
  logic [`CAM_VAL_W-1:0] value;
  // Valid in every APB access phase
  cam_rd_sel_e           rd_sel;

  modport decoder (output cmd_v, op, tag, value, rd_sel);
  modport sink    (input  cmd_v, op, tag, value, rd_sel);
endinterface

interface cam_res_if;
  logic                  res_v;
  logic                  hit;
  logic [`CAM_IDX_W-1:0] index;
  logic [`CAM_VAL_W-1:0] value;
  logic [`CAM_ELS-1:0]   empty;
  logic                  full;
  logic                  overflow;

  modport engine (output res_v, hit, index, value, empty, full, overflow);
  modport sink   (input  res_v, hit, index, value, empty, full, overflow);
endinterface

// File: rtl/cam_apb_decoder.sv
/* APB decoder for the CAM */
`include "cam_lookup_params.svh"

module cam_apb_decoder (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   psel_i,
  input  logic                   penable_i,
  input  logic                   pwrite_i,
  input  logic [`APB_ADDR_W-1:0] paddr_i,
  input  logic [`APB_DATA_W-1:0] pwdata_i,
  output logic                   pready_o,
  output logic                   pslverr_o,
  cam_cmd_if.decoder             cmd
);
  import cam_lookup_pkg::*;

  cam_wdata_u  wdata;
  cam_op_e     op_dec;
  cam_rd_sel_e rd_dec;
  logic        is_cmd;
  logic        is_rd;
  logic        access;
  logic        addr_ok;

  assign access = psel_i & penable_i;

  // Address map
  always_comb
  begin
    op_dec = OP_LOOKUP;
    rd_dec = RD_NONE;
    is_cmd = 1'b0;
    is_rd  = 1'b0;
    case (paddr_i)
      `CAM_REG_INSERT:
      begin
        op_dec = OP_INSERT;
        is_cmd = 1'b1;
      end
      `CAM_REG_DELETE:
      begin
        op_dec = OP_DELETE;
        is_cmd = 1'b1;
      end
      `CAM_REG_LOOKUP:
      begin
        op_dec = OP_LOOKUP;
        is_cmd = 1'b1;
      end
      `CAM_REG_RESULT:
      begin
        rd_dec = RD_RESULT;
        is_rd  = 1'b1;
      end
      `CAM_REG_STATUS:
      begin
        rd_dec = RD_STATUS;
        is_rd  = 1'b1;
      end
      default: ;
    endcase
  end

  // Writes go to command registers, reads to result registers
  assign addr_ok   = pwrite_i ? is_cmd : is_rd;
  assign pslverr_o = access & ~addr_ok;
  assign pready_o  = 1'b1;

  assign wdata = pwdata_i;

  assign cmd.cmd_v  = access & pwrite_i & is_cmd;
  assign cmd.op     = op_dec;
  assign cmd.tag    = (op_dec == OP_INSERT) ? wdata.ins.tag : wdata.key.tag;
  assign cmd.value  = wdata.ins.value;
  assign cmd.rd_sel = (access & ~pwrite_i & is_rd) ? rd_dec : RD_NONE;

  // Access phase always follows a setup phase
  a_apb_setup_first: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    penable_i |-> psel_i && $past(psel_i)
  ) else $error("penable high without psel or setup phase");

endmodule

// File: rtl/cam_tag_array.sv
/* CAM valid and tag storage */
`include "cam_lookup_params.svh"

module cam_tag_array (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  // Zero or one-hot
  input  logic [`CAM_ELS-1:0]   w_v_i,
  input  logic                  w_set_not_clear_i,
  input  logic [`CAM_TAG_W-1:0] w_tag_i,
  output logic [`CAM_ELS-1:0]   w_empty_o,
  input  logic                  r_v_i,
  input  logic [`CAM_TAG_W-1:0] r_tag_i,
  output logic [`CAM_ELS-1:0]   r_match_o
);

  logic [`CAM_ELS-1:0]                 v_r;
  logic [`CAM_ELS-1:0][`CAM_TAG_W-1:0] tag_r;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      v_r <= '0;
    else
      for (int i = 0; i < `CAM_ELS; i++)
        if (w_v_i[i])
          v_r[i] <= w_set_not_clear_i;
  end

  // Tags are only loaded on a set
  always_ff @(posedge clk_i)
  begin
    for (int i = 0; i < `CAM_ELS; i++)
      if (w_v_i[i] & w_set_not_clear_i)
        tag_r[i] <= w_tag_i;
  end

  for (genvar i = 0; i < `CAM_ELS; i++)
  begin : g_entry
    assign r_match_o[i] = r_v_i & v_r[i] & (tag_r[i] == r_tag_i);
    assign w_empty_o[i] = ~v_r[i];
  end

  // Engine keeps tags unique
  a_match_onehot0: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) $onehot0(r_match_o)
  ) else $error("multiple matching entries %b", r_match_o);

  a_set_onehot0: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(w_v_i & {`CAM_ELS{w_set_not_clear_i}})
  ) else $error("set write not one-hot %b", w_v_i);

endmodule

// File: rtl/cam_lookup_engine.sv
/* CAM insert, delete and lookup engine */
`include "cam_lookup_params.svh"

module cam_lookup_engine (
  input  logic     clk_i,
  input  logic     rst_n_i,
  cam_cmd_if.sink  cmd,
  cam_res_if.engine res
);
  import cam_lookup_pkg::*;

  logic [`CAM_ELS-1:0]   match;
  logic [`CAM_ELS-1:0]   empty;
  logic [`CAM_ELS-1:0]   free_oh;
  logic [`CAM_ELS-1:0]   w_v;
  logic                  w_set;
  logic                  hit;
  logic                  full;
  logic                  is_insert;
  logic                  overflow_r;
  logic [`CAM_IDX_W-1:0] match_idx;
  logic [`CAM_VAL_W-1:0] val_r [`CAM_ELS];

  cam_tag_array u_tag_array (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .w_v_i             (w_v),
    .w_set_not_clear_i (w_set),
    .w_tag_i           (cmd.tag),
    .w_empty_o         (empty),
    .r_v_i             (cmd.cmd_v),
    .r_tag_i           (cmd.tag),
    .r_match_o         (match)
  );

  assign hit       = |match;
  assign full      = ~|empty;
  assign is_insert = cmd.cmd_v & (cmd.op == OP_INSERT);
  assign w_set     = (cmd.op == OP_INSERT);

  // Lowest empty entry and match index
  always_comb
  begin
    free_oh   = '0;
    match_idx = '0;
    for (int i = `CAM_ELS - 1; i >= 0; i--)
      if (empty[i])
        free_oh = `CAM_ELS'(1) << i;
    for (int i = 0; i < `CAM_ELS; i++)
      if (match[i])
        match_idx = i[`CAM_IDX_W-1:0];
  end

  // Existing tag is overwritten in place; free_oh is zero when full
  always_comb
  begin
    w_v = '0;
    if (cmd.cmd_v)
      case (cmd.op)
        OP_INSERT: w_v = hit ? match : free_oh;
        OP_DELETE: w_v = match;
        default:   w_v = '0;
      endcase
  end

  always_ff @(posedge clk_i)
  begin
    for (int i = 0; i < `CAM_ELS; i++)
      if (w_v[i] & w_set)
        val_r[i] <= cmd.value;
  end

  // Sticky until reset
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      overflow_r <= 1'b0;
    else if (is_insert & ~hit & full)
      overflow_r <= 1'b1;
  end

  assign res.res_v    = cmd.cmd_v & (cmd.op == OP_LOOKUP);
  assign res.hit      = hit;
  assign res.index    = match_idx;
  assign res.value    = hit ? val_r[match_idx] : '0;
  assign res.empty    = empty;
  assign res.full     = full;
  assign res.overflow = overflow_r;

  // Insert writes exactly one entry unless it is dropped
  a_insert_one_entry: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    is_insert |-> ((full && !hit) ? (w_v == '0) : $onehot(w_v))
  ) else $error("insert selected entries %b", w_v);

endmodule

// File: rtl/cam_result_regs.sv
/* CAM result latch and read mux */
`include "cam_lookup_params.svh"

module cam_result_regs (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  cam_cmd_if.sink                cmd,
  cam_res_if.sink                res,
  output logic [`APB_DATA_W-1:0] prdata_o
);
  import cam_lookup_pkg::*;

  logic                   hit_r;
  logic [`CAM_IDX_W-1:0]  idx_r;
  logic [`CAM_VAL_W-1:0]  val_r;
  logic [`APB_DATA_W-1:0] result_word;
  logic [`APB_DATA_W-1:0] status_word;

  // Latched on each lookup
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      hit_r <= 1'b0;
      idx_r <= '0;
      val_r <= '0;
    end
    else if (res.res_v)
    begin
      hit_r <= res.hit;
      idx_r <= res.index;
      val_r <= res.value;
    end
  end

  // hit at 31, index at 26..24, value at 15..0
  assign result_word = {hit_r, 4'b0, idx_r, 8'b0, val_r};

  // Live table state
  assign status_word = {{(`APB_DATA_W-`CAM_ELS-2){1'b0}}, res.overflow, res.full, res.empty};

  always_comb
  begin
    case (cmd.rd_sel)
      RD_RESULT: prdata_o = result_word;
      RD_STATUS: prdata_o = status_word;
      default:   prdata_o = '0;
    endcase
  end

endmodule

// File: rtl/cam_lookup_top.sv
/* CAM lookup with APB port */
`include "cam_lookup_params.svh"

module cam_lookup_top (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   psel_i,
  input  logic                   penable_i,
  input  logic                   pwrite_i,
  input  logic [`APB_ADDR_W-1:0] paddr_i,
  input  logic [`APB_DATA_W-1:0] pwdata_i,
  output logic [`APB_DATA_W-1:0] prdata_o,
  output logic                   pready_o,
  output logic                   pslverr_o
);

  cam_cmd_if cmd_if ();
  cam_res_if res_if ();

  cam_apb_decoder u_decoder (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (paddr_i),
    .pwdata_i  (pwdata_i),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o),
    .cmd       (cmd_if.decoder)
  );

  cam_lookup_engine u_engine (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .cmd     (cmd_if.sink),
    .res     (res_if.engine)
  );

  cam_result_regs u_result_regs (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .cmd      (cmd_if.sink),
    .res      (res_if.sink),
    .prdata_o (prdata_o)
  );

endmodule

// File: tests/tb_cam_lookup.sv
/* CAM lookup APB testbench */
`include "cam_lookup_params.svh"

module tb_cam_lookup;
  timeunit 1ns;
  timeprecision 1ps;

  logic                   clk;
  logic                   rst_n;
  logic                   psel;
  logic                   penable;
  logic                   pwrite;
  logic [`APB_ADDR_W-1:0] paddr;
  logic [`APB_DATA_W-1:0] pwdata;
  logic [`APB_DATA_W-1:0] prdata;
  logic                   pready;
  logic                   pslverr;

  int    cycles;
  int    limit;
  int    n_tests;
  int    n_checks;
  int    n_errors;
  int    test_checks;
  int    test_errors;
  string cur_test;

  cam_lookup_top u_cam_lookup_top (
    .clk_i     (clk),
    .rst_n_i   (rst_n),
    .psel_i    (psel),
    .penable_i (penable),
    .pwrite_i  (pwrite),
    .paddr_i   (paddr),
    .pwdata_i  (pwdata),
    .prdata_o  (prdata),
    .pready_o  (pready),
    .pslverr_o (pslverr)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Guard against a stuck transfer
  always @(posedge clk)
  begin
    cycles++;
    if (limit > 0 && cycles > limit)
    begin
      $display("timeout: run did not finish within %0d cycles", limit);
      $display("Test failed");
      $finish;
    end
  end

  function automatic string strip_eol(string s);
    string r;
    r = s;
    while (r.len() > 0 && (r[r.len()-1] == "\n" || r[r.len()-1] == "\r"
           || r[r.len()-1] == " "))
      r = r.substr(0, r.len() - 2);
    return r;
  endfunction

  // Setup and access phase sampled at the completing rising edge
  task automatic apb_transfer(input logic wr, input logic [`APB_ADDR_W-1:0] addr,
                              input logic [`APB_DATA_W-1:0] data,
                              output logic [`APB_DATA_W-1:0] rdata, output logic err,
                              output logic rdy);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wr ? data : '0;
    @(negedge clk);
    penable = 1'b1;
    // Zero wait states, so the first access edge completes the transfer
    @(posedge clk);
    rdata = prdata;
    err   = pslverr;
    rdy   = pready;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic compare_value(string sig, logic [`APB_DATA_W-1:0] got,
                               logic [`APB_DATA_W-1:0] exp, int lineno);
    test_checks++;
    assert (got === exp)
    else
    begin
      $display("FAILED %s: got %h expected %h (%s, line %0d)", sig, got, exp,
               cur_test, lineno);
      test_errors++;
    end
  endtask

  task automatic close_test();
    if (cur_test != "")
    begin
      $display("test %s: %0d checks, %0d errors", cur_test, test_checks, test_errors);
      n_tests++;
      n_checks += test_checks;
      n_errors += test_errors;
    end
    test_checks = 0;
    test_errors = 0;
  endtask

  task automatic run_vectors(int fd);
    string                  line;
    int                     lineno;
    int                     code;
    logic [`APB_ADDR_W-1:0] addr;
    logic [`APB_DATA_W-1:0] data;
    logic [`APB_DATA_W-1:0] rdata;
    logic                   exp_err;
    logic                   err;
    logic                   rdy;
    lineno = 0;
    while ($fgets(line, fd) > 0)
    begin
      lineno++;
      if (line.len() == 0 || line[0] == "#" || line[0] == "\n")
        continue;
      if (line[0] == "T")
      begin
        close_test();
        cur_test = strip_eol(line.substr(2, line.len() - 1));
        continue;
      end
      code = $sscanf(line.substr(1, line.len() - 1), "%h %h %h", addr, data, exp_err);
      if (code != 3 || (line[0] != "W" && line[0] != "R"))
      begin
        $display("vector line %0d could not be parsed", lineno);
        test_errors++;
      end
      else
      begin
        apb_transfer(line[0] == "W", addr, data, rdata, err, rdy);
        // Read data matters only on reads
        if (line[0] == "R")
          compare_value("prdata", rdata, data, lineno);
        compare_value("pslverr", {31'b0, err}, {31'b0, exp_err}, lineno);
        compare_value("pready", {31'b0, rdy}, 32'h1, lineno);
      end
    end
  endtask

  initial
  begin
    int    fd;
    int    nvec;
    string line;
    rst_n    = 1'b0;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    limit    = 0;
    cur_test = "";
    fd = $fopen("tests/cam_lookup_vectors.txt", "r");
    if (fd == 0)
    begin
      $display("vector file tests/cam_lookup_vectors.txt could not be opened");
      $display("Test failed");
      $finish;
    end
    else
    begin
      // Size the timeout from the number of transfers
      nvec = 0;
      while ($fgets(line, fd) > 0)
        if (line.len() > 0 && (line[0] == "W" || line[0] == "R"))
          nvec++;
      $fclose(fd);
      limit = 6 * nvec + 20;
      repeat (8) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      fd = $fopen("tests/cam_lookup_vectors.txt", "r");
      run_vectors(fd);
      $fclose(fd);
      close_test();
      $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
      if (n_errors == 0)
        $display("Test completed successfully");
      else
        $display("Test failed");
      $finish;
    end
  end

endmodule

// File: cam_lookup.f
+incdir+rtl
rtl/cam_lookup_pkg.sv
rtl/cam_lookup_if.sv
rtl/cam_apb_decoder.sv
rtl/cam_tag_array.sv
rtl/cam_lookup_engine.sv
rtl/cam_result_regs.sv
rtl/cam_lookup_top.sv
tests/tb_cam_lookup.sv

// File: Makefile
SIM        = verilator
TOP        = tb_cam_lookup
FILELIST   = cam_lookup.f
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing
OBJ_DIR    = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Test completed successfully"

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: tests/cam_lookup_vectors.txt
# Columns: op addr data err. W drives data, R expects data on prdata.
# err is the expected pslverr. A T line starts a named test.
T reset_state
R 10 000000FF 0
R 0C 00000000 0
T insert_lookup
W 00 00115A5A 0
W 00 0022BEEF 0
W 08 00000022 0
R 0C 8100BEEF 0
R 10 000000FC 0
T lookup_miss
W 08 00000033 0
R 0C 00000000 0
T overwrite
W 00 00111234 0
W 08 00000011 0
R 0C 80001234 0
R 10 000000FC 0
T delete_reuse
W 04 00000011 0
W 08 00000011 0
R 0C 00000000 0
R 10 000000FD 0
W 00 00444444 0
W 08 00000044 0
R 0C 80004444 0
R 10 000000FC 0
T full_overflow
W 00 00555555 0
W 00 00666666 0
W 00 00777777 0
W 00 00888888 0
W 00 00999999 0
W 00 00AAAAAA 0
R 10 00000100 0
W 00 00BBBBBB 0
R 10 00000300 0
W 08 000000BB 0
R 0C 00000000 0
T bad_access
W 0C 00123456 1
R 0C 00000000 0
R 00 00000000 1
R 14 00000000 1
W 14 00115A5A 1
R 10 00000300 0
W 08 00000022 0
R 0C 8100BEEF 0
